// ==== hdl/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Data width of the hart
`define XLEN 32

// Optional extensions
`define SSTC_SUPPORTED    1
`define VIRTMEM_SUPPORTED 1

////////////////////////////////////////////////////////////////////////////
// Supervisor CSR addresses
////////////////////////////////////////////////////////////////////////////
`define CSR_SSTATUS    12'h100
`define CSR_SIE        12'h104
`define CSR_STVEC      12'h105
`define CSR_SCOUNTEREN 12'h106
`define CSR_SENVCFG    12'h10A
`define CSR_SSCRATCH   12'h140
`define CSR_SEPC       12'h141
`define CSR_SCAUSE     12'h142
`define CSR_STVAL      12'h143
`define CSR_SIP        12'h144
`define CSR_STIMECMP   12'h14D
`define CSR_STIMECMPH  12'h15D
`define CSR_SATP       12'h180

////////////////////////////////////////////////////////////////////////////
// Machine CSR addresses
////////////////////////////////////////////////////////////////////////////
`define CSR_MSTATUS    12'h300
`define CSR_MEDELEG    12'h302
`define CSR_MIDELEG    12'h303
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MCOUNTEREN 12'h306
`define CSR_MENVCFG    12'h30A
`define CSR_MENVCFGH   12'h31A
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343
`define CSR_MIP        12'h344
// Custom machine timer compare
`define CSR_MTIMECMP   12'h7C0
`define CSR_MTIMECMPH  12'h7C1
// Unprivileged time counter, read only
`define CSR_TIME       12'hC01
`define CSR_TIMEH      12'hC81

// mstatus bit positions
`define MSTATUS_SIE  1
`define MSTATUS_MIE  3
`define MSTATUS_SPIE 5
`define MSTATUS_MPIE 7
`define MSTATUS_SPP  8
`define MSTATUS_TVM  20

// Writable fields: SIE MIE SPIE MPIE SPP MPP SUM MXR TVM
`define MSTATUS_MASK   32'h001C_19AA
// SIE SPIE SPP SUM MXR
`define SSTATUS_MASK   32'h000C_0122
`define MEDELEG_MASK   32'h0000_B3FF
`define SUPER_INT_MASK 12'h222
`define MIE_MASK       12'hAAA
// Software may set SSIP and SEIP only
`define MIP_WR_MASK    12'h202

`endif

// ==== hdl/csrPkg.sv ====
`default_nettype none

package csrPkg;

  //////////////////////////////////////////////////////////////////////////
  // Privilege levels
  //////////////////////////////////////////////////////////////////////////

  // Encoding follows the privileged spec, 2'b10 is reserved
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } privMode_t;

  //////////////////////////////////////////////////////////////////////////
  // Wishbone responder
  //////////////////////////////////////////////////////////////////////////

  // Idle waits for a request
  // Resp drives ack or err for one cycle
  typedef enum logic {
    BUS_IDLE = 1'b0,
    BUS_RESP = 1'b1
  } busState_t;

endpackage

`default_nettype wire

// ==== hdl/csrAccessCtl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csrAccessCtl (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire logic              cyc,
  input  wire logic              stb,
  input  wire logic              we,
  input  wire logic [11:0]       adr,
  input  wire logic [`XLEN-1:0]  datWr,
  output logic [`XLEN-1:0]       datRd,
  output logic                   ack,
  output logic                   err,
  input  wire csrPkg::privMode_t privMode,
  output logic [11:0]            csrAdr,
  output logic [`XLEN-1:0]       csrWrVal,
  output logic                   mWrite,
  output logic                   sWrite,
  input  wire logic [`XLEN-1:0]  mRdVal,
  input  wire logic [`XLEN-1:0]  sRdVal,
  input  wire logic              mIllegal,
  input  wire logic              sIllegal
);
  import csrPkg::*;

  busState_t state;
  logic      req;
  logic      toSuper;
  logic      privLow;
  logic      roFault;
  logic      fault;

  // Both blocks decode the live bus address
  assign csrAdr   = adr;
  assign csrWrVal = datWr;

  // New request only while idle
  assign req     = (state == BUS_IDLE) && cyc && stb;
  // Level 01 belongs to the supervisor block
  assign toSuper = adr[9:8] == 2'b01;
  assign privLow = privMode < adr[9:8];
  // Top address bits 11 mark read-only space
  assign roFault = we && (adr[11:10] == 2'b11);
  assign fault   = privLow || roFault || (toSuper ? sIllegal : mIllegal);

  // Strobe only for accesses that will be acked
  assign mWrite = req && we && !fault && !toSuper;
  assign sWrite = req && we && !fault && toSuper;

  ////////////////////////////////////////////////////////////////////////////
  // Responder FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= BUS_IDLE;
      ack   <= 1'b0;
      err   <= 1'b0;
    end else begin
      ack <= req && !fault;
      err <= req && fault;
      case (state)
        BUS_IDLE: if (req) state <= BUS_RESP;
        BUS_RESP: state <= BUS_IDLE;
        default:  state <= BUS_IDLE;
      endcase
    end
  end

  // Read data sampled with the request, value before any write
  always_ff @(posedge clk) begin
    if (req)
      datRd <= fault ? '0 : (toSuper ? sRdVal : mRdVal);
  end

  // One-cycle, single-kind response
  assert property (@(posedge clk) disable iff (!rstN)
    (ack || err) |-> !(ack && err) ##1 !(ack || err));

  // A write strobe goes to one block and is always acked
  assert property (@(posedge clk) disable iff (!rstN)
    (mWrite || sWrite) |-> !(mWrite && sWrite) ##1 ack);

endmodule

`default_nettype wire

// ==== hdl/machineCsrs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module machineCsrs (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire csrPkg::privMode_t privMode,
  input  wire logic [11:0]       csrAdr,
  input  wire logic [`XLEN-1:0]  csrWrVal,
  input  wire logic              mWrite,
  input  wire logic              writeSstatus,
  input  wire logic              trapValid,
  input  wire logic [4:0]        trapCause,
  input  wire logic [`XLEN-1:0]  trapEpc,
  input  wire logic [`XLEN-1:0]  trapTval,
  input  wire logic              sTimerInt,
  output logic [`XLEN-1:0]       mRdVal,
  output logic                   mIllegal,
  output logic                   superTrap,
  output logic [`XLEN-1:0]       mstatusVal,
  output logic [11:0]            mipVal,
  output logic [11:0]            mieVal,
  output logic [11:0]            midelegVal,
  output logic                   mcounterenTm,
  output logic                   menvcfgStce,
  output logic [63:0]            timeVal,
  output logic                   mTimerInt,
  output logic [`XLEN-1:0]       mtvecOut
);
  import csrPkg::*;

  logic [`XLEN-1:0] mstatusReg;
  logic [`XLEN-1:0] medelegReg;
  logic [`XLEN-1:0] mtvecReg;
  logic [`XLEN-1:0] mscratchReg;
  logic [`XLEN-1:0] mepcReg;
  logic [`XLEN-1:0] mcauseReg;
  logic [`XLEN-1:0] mtvalReg;
  logic [11:0]      mieReg;
  logic [11:0]      mipSwReg;
  logic [11:0]      midelegReg;
  logic [15:0]      midelegExt;
  logic [2:0]       mcounterenReg;
  logic             menvcfgFiom;
  logic             menvcfgStceReg;
  logic [63:0]      timeCnt;
  logic [63:0]      mtimecmpReg;
  logic             delegBit;
  logic             machTrap;
  logic [`XLEN-1:0] causeVal;

  ////////////////////////////////////////////////////////////////////////////
  // Trap delegation
  ////////////////////////////////////////////////////////////////////////////

  // Cause code indexes mideleg for interrupts, medeleg otherwise
  assign midelegExt = {4'b0, midelegReg};
  assign delegBit   = trapCause[4] ? midelegExt[trapCause[3:0]] : medelegReg[trapCause[3:0]];
  // M-mode traps are never delegated
  assign superTrap  = trapValid && (privMode != PRIV_M) && delegBit;
  assign machTrap   = trapValid && !superTrap;
  // Interrupt flag in the top bit
  assign causeVal   = {trapCause[4], 27'b0, trapCause[3:0]};

  // Timer pending bits come straight from the compares
  assign mipVal    = mipSwReg | {4'b0, mTimerInt, 1'b0, sTimerInt, 5'b0};
  assign mTimerInt = timeCnt >= mtimecmpReg;

  // Views for the supervisor block
  assign mstatusVal   = mstatusReg;
  assign mieVal       = mieReg;
  assign midelegVal   = midelegReg;
  assign mcounterenTm = mcounterenReg[1];
  assign menvcfgStce  = menvcfgStceReg;
  assign timeVal      = timeCnt;
  assign mtvecOut     = mtvecReg;

  ////////////////////////////////////////////////////////////////////////////
  // Register update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mstatusReg     <= '0;
      medelegReg     <= '0;
      mtvecReg       <= '0;
      mscratchReg    <= '0;
      mepcReg        <= '0;
      mcauseReg      <= '0;
      mtvalReg       <= '0;
      mieReg         <= '0;
      mipSwReg       <= '0;
      midelegReg     <= '0;
      mcounterenReg  <= '0;
      menvcfgFiom    <= 1'b0;
      menvcfgStceReg <= 1'b0;
      timeCnt        <= '0;
      // Far future, no timer interrupt out of reset
      mtimecmpReg    <= '1;
    end else begin
      // Free running
      timeCnt <= timeCnt + 64'd1;
      if (mWrite) begin
        case (csrAdr)
          `CSR_MSTATUS:    mstatusReg <= csrWrVal & `MSTATUS_MASK;
          `CSR_MEDELEG:    medelegReg <= csrWrVal & `MEDELEG_MASK;
          `CSR_MIDELEG:    midelegReg <= csrWrVal[11:0] & `SUPER_INT_MASK;
          `CSR_MIE:        mieReg <= csrWrVal[11:0] & `MIE_MASK;
          `CSR_MIP:        mipSwReg <= csrWrVal[11:0] & `MIP_WR_MASK;
          `CSR_MTVEC:      mtvecReg <= {csrWrVal[31:2], 1'b0, csrWrVal[0]};
          `CSR_MCOUNTEREN: mcounterenReg <= csrWrVal[2:0];
          `CSR_MENVCFG:    menvcfgFiom <= csrWrVal[0];
          `CSR_MENVCFGH:   menvcfgStceReg <= csrWrVal[31];
          `CSR_MSCRATCH:   mscratchReg <= csrWrVal;
          `CSR_MEPC:       mepcReg <= csrWrVal;
          `CSR_MCAUSE:     mcauseReg <= csrWrVal;
          `CSR_MTVAL:      mtvalReg <= csrWrVal;
          `CSR_MTIMECMP:   mtimecmpReg[31:0] <= csrWrVal;
          `CSR_MTIMECMPH:  mtimecmpReg[63:32] <= csrWrVal;
          default: ;
        endcase
      end
      // sstatus writes touch only the shared fields
      if (writeSstatus)
        mstatusReg <= (mstatusReg & ~`SSTATUS_MASK) | (csrWrVal & `SSTATUS_MASK);
      // Traps come last so they override a bus write
      if (superTrap) begin
        mstatusReg[`MSTATUS_SPIE] <= mstatusReg[`MSTATUS_SIE];
        mstatusReg[`MSTATUS_SIE]  <= 1'b0;
        mstatusReg[`MSTATUS_SPP]  <= (privMode == PRIV_S);
      end else if (machTrap) begin
        mstatusReg[`MSTATUS_MPIE] <= mstatusReg[`MSTATUS_MIE];
        mstatusReg[`MSTATUS_MIE]  <= 1'b0;
        mstatusReg[12:11]         <= privMode;
        mepcReg                   <= trapEpc;
        mcauseReg                 <= causeVal;
        mtvalReg                  <= trapTval;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mIllegal = 1'b0;
    case (csrAdr)
      `CSR_MSTATUS:    mRdVal = mstatusReg;
      `CSR_MEDELEG:    mRdVal = medelegReg;
      `CSR_MIDELEG:    mRdVal = {20'b0, midelegReg};
      `CSR_MIE:        mRdVal = {20'b0, mieReg};
      `CSR_MIP:        mRdVal = {20'b0, mipVal};
      `CSR_MTVEC:      mRdVal = mtvecReg;
      `CSR_MCOUNTEREN: mRdVal = {29'b0, mcounterenReg};
      `CSR_MENVCFG:    mRdVal = {31'b0, menvcfgFiom};
      `CSR_MENVCFGH:   mRdVal = {menvcfgStceReg, 31'b0};
      `CSR_MSCRATCH:   mRdVal = mscratchReg;
      `CSR_MEPC:       mRdVal = mepcReg;
      `CSR_MCAUSE:     mRdVal = mcauseReg;
      `CSR_MTVAL:      mRdVal = mtvalReg;
      `CSR_MTIMECMP:   mRdVal = mtimecmpReg[31:0];
      `CSR_MTIMECMPH:  mRdVal = mtimecmpReg[63:32];
      `CSR_TIME:       mRdVal = timeCnt[31:0];
      `CSR_TIMEH:      mRdVal = timeCnt[63:32];
      default: begin
        mRdVal   = '0;
        mIllegal = 1'b1;
      end
    endcase
  end

  // A delegated trap leaves the machine trap registers alone
  assert property (@(posedge clk) disable iff (!rstN)
    superTrap && !mWrite |=> $stable(mepcReg) && $stable(mcauseReg) && $stable(mtvalReg));

endmodule

`default_nettype wire

// ==== hdl/supervisorCsrs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module supervisorCsrs (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire csrPkg::privMode_t privMode,
  input  wire logic [11:0]       csrAdr,
  input  wire logic [`XLEN-1:0]  csrWrVal,
  input  wire logic              sWrite,
  input  wire logic              superTrap,
  input  wire logic [4:0]        trapCause,
  input  wire logic [`XLEN-1:0]  trapEpc,
  input  wire logic [`XLEN-1:0]  trapTval,
  input  wire logic [`XLEN-1:0]  mstatusVal,
  input  wire logic [11:0]       mipVal,
  input  wire logic [11:0]       mieVal,
  input  wire logic [11:0]       midelegVal,
  input  wire logic              mcounterenTm,
  input  wire logic              menvcfgStce,
  input  wire logic [63:0]       timeVal,
  output logic [`XLEN-1:0]       sRdVal,
  output logic                   sIllegal,
  output logic                   writeSstatus,
  output logic                   sTimerInt,
  output logic [`XLEN-1:0]       stvecOut,
  output logic [`XLEN-1:0]       sepcOut,
  output logic [`XLEN-1:0]       satpOut
);
  import csrPkg::*;

  logic [`XLEN-1:0] stvecReg;
  logic [`XLEN-1:0] sscratchReg;
  logic [`XLEN-1:0] sepcReg;
  logic [`XLEN-1:0] scauseReg;
  logic [`XLEN-1:0] stvalReg;
  logic [`XLEN-1:0] satpReg;
  logic [2:0]       scounterenReg;
  logic             senvcfgFiom;
  logic [63:0]      stimecmpReg;
  logic             satpOk;
  logic             stcOk;

  // satp trapped to M mode while TVM is set
  assign satpOk = `VIRTMEM_SUPPORTED && (privMode == PRIV_M || !mstatusVal[`MSTATUS_TVM]);
  // stimecmp opened to S mode by both TM and STCE
  assign stcOk  = `SSTC_SUPPORTED && (privMode == PRIV_M || (mcounterenTm && menvcfgStce));

  // sstatus lives in mstatus
  assign writeSstatus = sWrite && (csrAdr == `CSR_SSTATUS);

  // Unsigned compare against the shared time counter
  assign sTimerInt = `SSTC_SUPPORTED && (timeVal >= stimecmpReg);

  assign stvecOut = stvecReg;
  assign sepcOut  = sepcReg;
  assign satpOut  = satpReg;

  ////////////////////////////////////////////////////////////////////////////
  // Register update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stvecReg      <= '0;
      sscratchReg   <= '0;
      sepcReg       <= '0;
      scauseReg     <= '0;
      stvalReg      <= '0;
      satpReg       <= '0;
      scounterenReg <= '0;
      senvcfgFiom   <= 1'b0;
      stimecmpReg   <= '1;
    end else begin
      if (sWrite) begin
        case (csrAdr)
          // Mode field bit 1 is reserved
          `CSR_STVEC:      stvecReg <= {csrWrVal[31:2], 1'b0, csrWrVal[0]};
          `CSR_SSCRATCH:   sscratchReg <= csrWrVal;
          `CSR_SEPC:       sepcReg <= csrWrVal;
          `CSR_SCAUSE:     scauseReg <= csrWrVal;
          `CSR_STVAL:      stvalReg <= csrWrVal;
          `CSR_SCOUNTEREN: scounterenReg <= csrWrVal[2:0];
          `CSR_SENVCFG:    senvcfgFiom <= csrWrVal[0];
          `CSR_SATP:       if (satpOk) satpReg <= csrWrVal;
          `CSR_STIMECMP:   if (stcOk) stimecmpReg[31:0] <= csrWrVal;
          `CSR_STIMECMPH:  if (stcOk) stimecmpReg[63:32] <= csrWrVal;
          default: ;
        endcase
      end
      // Delegated trap beats a same-cycle write
      if (superTrap) begin
        sepcReg   <= trapEpc;
        scauseReg <= {trapCause[4], 27'b0, trapCause[3:0]};
        stvalReg  <= trapTval;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sIllegal = 1'b0;
    case (csrAdr)
      `CSR_SSTATUS:    sRdVal = mstatusVal & `SSTATUS_MASK;
      // Only delegated supervisor interrupts show through
      `CSR_SIE:        sRdVal = {20'b0, mieVal & `SUPER_INT_MASK & midelegVal};
      `CSR_SIP:        sRdVal = {20'b0, mipVal & `SUPER_INT_MASK & midelegVal};
      `CSR_STVEC:      sRdVal = stvecReg;
      `CSR_SCOUNTEREN: sRdVal = {29'b0, scounterenReg};
      `CSR_SENVCFG:    sRdVal = {31'b0, senvcfgFiom};
      `CSR_SSCRATCH:   sRdVal = sscratchReg;
      `CSR_SEPC:       sRdVal = sepcReg;
      `CSR_SCAUSE:     sRdVal = scauseReg;
      `CSR_STVAL:      sRdVal = stvalReg;
      `CSR_SATP: begin
        sRdVal   = satpOk ? satpReg : '0;
        sIllegal = !satpOk;
      end
      `CSR_STIMECMP: begin
        sRdVal   = stcOk ? stimecmpReg[31:0] : '0;
        sIllegal = !stcOk;
      end
      `CSR_STIMECMPH: begin
        sRdVal   = stcOk ? stimecmpReg[63:32] : '0;
        sIllegal = !stcOk;
      end
      default: begin
        sRdVal   = '0;
        sIllegal = 1'b1;
      end
    endcase
  end

  // stimecmp moves only on a write that passed the gate
  assert property (@(posedge clk) disable iff (!rstN)
    !$stable(stimecmpReg) |-> $past(sWrite && stcOk &&
      (csrAdr == `CSR_STIMECMP || csrAdr == `CSR_STIMECMPH)));

endmodule

`default_nettype wire

// ==== hdl/csrUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csrUnit (
  input  wire logic              clk,
  input  wire logic              rstN,
  // Wishbone classic slave
  input  wire logic              cyc,
  input  wire logic              stb,
  input  wire logic              we,
  input  wire logic [11:0]       adr,
  input  wire logic [`XLEN-1:0]  datWr,
  output logic [`XLEN-1:0]       datRd,
  output logic                   ack,
  output logic                   err,
  // Core side
  input  wire csrPkg::privMode_t privMode,
  input  wire logic              trapValid,
  input  wire logic [4:0]        trapCause,
  input  wire logic [`XLEN-1:0]  trapEpc,
  input  wire logic [`XLEN-1:0]  trapTval,
  output logic                   mTimerInt,
  output logic                   sTimerInt,
  output logic [`XLEN-1:0]       stvecOut,
  output logic [`XLEN-1:0]       sepcOut,
  output logic [`XLEN-1:0]       satpOut,
  output logic [`XLEN-1:0]       mtvecOut
);

  // Access control to register blocks
  logic [11:0]      csrAdr;
  logic [`XLEN-1:0] csrWrVal;
  logic             mWrite;
  logic             sWrite;
  logic [`XLEN-1:0] mRdVal;
  logic [`XLEN-1:0] sRdVal;
  logic             mIllegal;
  logic             sIllegal;
  // Machine block to supervisor block
  logic             superTrap;
  logic [`XLEN-1:0] mstatusVal;
  logic [11:0]      mipVal;
  logic [11:0]      mieVal;
  logic [11:0]      midelegVal;
  logic             mcounterenTm;
  logic             menvcfgStce;
  logic [63:0]      timeVal;
  logic             writeSstatus;

  csrAccessCtl accessCtl (
    .clk, .rstN, .cyc, .stb, .we, .adr, .datWr, .datRd, .ack, .err,
    .privMode, .csrAdr, .csrWrVal, .mWrite, .sWrite,
    .mRdVal, .sRdVal, .mIllegal, .sIllegal
  );

  machineCsrs mRegs (
    .clk, .rstN, .privMode, .csrAdr, .csrWrVal, .mWrite, .writeSstatus,
    .trapValid, .trapCause, .trapEpc, .trapTval, .sTimerInt,
    .mRdVal, .mIllegal, .superTrap, .mstatusVal, .mipVal, .mieVal,
    .midelegVal, .mcounterenTm, .menvcfgStce, .timeVal, .mTimerInt, .mtvecOut
  );

  supervisorCsrs sRegs (
    .clk, .rstN, .privMode, .csrAdr, .csrWrVal, .sWrite, .superTrap,
    .trapCause, .trapEpc, .trapTval, .mstatusVal, .mipVal, .mieVal,
    .midelegVal, .mcounterenTm, .menvcfgStce, .timeVal,
    .sRdVal, .sIllegal, .writeSstatus, .sTimerInt, .stvecOut, .sepcOut, .satpOut
  );

endmodule

`default_nettype wire

// ==== verif/csrBusTasks.svh ====
`ifndef CSR_BUS_TASKS_SVH
`define CSR_BUS_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Wishbone master
////////////////////////////////////////////////////////////////////////////

// Look at ack and err only at the falling edge
task automatic waitResp();
  int cnt;
  cnt = 0;
  do begin
    @(negedge clk);
    cnt++;
  end while (!(ack || err) && cnt < RespLimit);
  if (ack || err) begin
    rdData = datRd;
  end else begin
    $display("Timeout at %0t: no ack or err for address %h", $time, adr);
    errCount++;
  end
endtask

task automatic writeCsr(input logic [11:0] a, input logic [31:0] d, input logic okExp);
  @(posedge clk);
  cyc     <= 1'b1;
  stb     <= 1'b1;
  we      <= 1'b1;
  adr     <= a;
  datWr   <= d;
  expAck  <= okExp;
  chkData <= 1'b0;
  waitResp();
  // Bus released one edge after the response
  @(posedge clk);
  cyc <= 1'b0;
  stb <= 1'b0;
  we  <= 1'b0;
endtask

task automatic readCsr(input logic [11:0] a, input logic okExp,
                       input logic [31:0] d, input logic chk);
  @(posedge clk);
  cyc     <= 1'b1;
  stb     <= 1'b1;
  we      <= 1'b0;
  adr     <= a;
  expAck  <= okExp;
  expData <= d;
  chkData <= chk;
  waitResp();
  @(posedge clk);
  cyc <= 1'b0;
  stb <= 1'b0;
endtask

////////////////////////////////////////////////////////////////////////////
// Core side
////////////////////////////////////////////////////////////////////////////

task automatic setPriv(input privMode_t m);
  @(posedge clk);
  privMode <= m;
endtask

// Trap report held for one clock
task automatic raiseTrap(input logic [4:0] cause, input logic [31:0] epc,
                         input logic [31:0] tval);
  @(posedge clk);
  trapValid <= 1'b1;
  trapCause <= cause;
  trapEpc   <= epc;
  trapTval  <= tval;
  @(posedge clk);
  trapValid <= 1'b0;
endtask

task automatic waitIrq(input bit useMachine);
  int cnt;
  cnt = 0;
  while (!(useMachine ? mTimerInt : sTimerInt) && cnt < TimerLimit) begin
    @(negedge clk);
    cnt++;
  end
  checkTrue(useMachine ? mTimerInt : sTimerInt, "timer interrupt did not rise in time");
endtask

// Interrupt must stay low over a short window
task automatic expectQuiet(input bit useMachine);
  int cnt;
  bit seen;
  seen = 1'b0;
  for (cnt = 0; cnt < 20; cnt++) begin
    @(negedge clk);
    if (useMachine ? mTimerInt : sTimerInt)
      seen = 1'b1;
  end
  checkTrue(!seen, "timer interrupt rose while its compare was far ahead");
endtask

////////////////////////////////////////////////////////////////////////////
// Result counting
////////////////////////////////////////////////////////////////////////////

task automatic startTest();
  errAtStart = errCount;
endtask

task automatic finishTest(input string name);
  // Let the last response check settle
  @(negedge clk);
  testCount++;
  if (errCount == errAtStart) begin
    $display("Test %0d %s: ok", testCount, name);
  end else begin
    failCount++;
    $display("Test %0d %s: FAILED with %0d errors", testCount, name, errCount - errAtStart);
  end
endtask

`endif

// ==== verif/csrUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csrUnitTb;
  import csrPkg::*;

  localparam int RespLimit  = 20;
  localparam int TimerLimit = 200;

  logic        clk;
  logic        rstN;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [11:0] adr;
  logic [31:0] datWr;
  logic [31:0] datRd;
  logic        ack;
  logic        err;
  privMode_t   privMode;
  logic        trapValid;
  logic [4:0]  trapCause;
  logic [31:0] trapEpc;
  logic [31:0] trapTval;
  logic        mTimerInt;
  logic        sTimerInt;
  logic [31:0] stvecOut;
  logic [31:0] sepcOut;
  logic [31:0] satpOut;
  logic [31:0] mtvecOut;

  // Expected response of the access in flight
  logic        expAck;
  logic        chkData;
  logic [31:0] expData;
  logic [31:0] rdData;

  integer      seed;
  int          errCount;
  int          errAtStart;
  int          testCount;
  int          failCount;
  logic [31:0] randVal;
  logic [31:0] scratchVal;
  logic [31:0] cmpVal;

  csrUnit DUT (
    .clk, .rstN, .cyc, .stb, .we, .adr, .datWr, .datRd, .ack, .err,
    .privMode, .trapValid, .trapCause, .trapEpc, .trapTval,
    .mTimerInt, .sTimerInt, .stvecOut, .sepcOut, .satpOut, .mtvecOut
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  `include "csrBusTasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Response checks
  ////////////////////////////////////////////////////////////////////////////

  // ack for legal accesses, err for the rest
  assert property (@(posedge clk) disable iff (!rstN)
    (ack || err) |-> (ack == expAck) && (err == !expAck))
    else begin
      $display("Error at %0t: ack = %b, expected %b", $time, $sampled(ack),
        $sampled(expAck));
      errCount++;
    end

  // Read data against the value from the register rules
  assert property (@(posedge clk) disable iff (!rstN)
    (ack && chkData) |-> datRd == expData)
    else begin
      $display("Error at %0t: datRd = %h, expected %h", $time, $sampled(datRd),
        $sampled(expData));
      errCount++;
    end

  task automatic checkVal(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        errCount++;
      end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    assert (cond === 1'b1)
      else begin
        $display("Check failed at %0t: %s", $time, what);
        errCount++;
      end
  endtask

  task automatic endRun();
    $display("Tests run %0d, failed %0d, errors %0d", testCount, failCount, errCount);
    if (errCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed      = 32'h6eb;
    errCount  = 0;
    testCount = 0;
    failCount = 0;
    rstN      = 1'b0;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    datWr     = '0;
    privMode  = PRIV_M;
    trapValid = 1'b0;
    trapCause = '0;
    trapEpc   = '0;
    trapTval  = '0;
    expAck    = 1'b1;
    chkData   = 1'b0;
    expData   = '0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;

    // Reset values
    startTest();
    @(negedge clk);
    checkTrue(!ack && !err, "bus response active after reset");
    checkVal("mTimerInt", mTimerInt, 0);
    checkVal("sTimerInt", sTimerInt, 0);
    readCsr(`CSR_STVEC, 1, 0, 1);
    readCsr(`CSR_SEPC, 1, 0, 1);
    readCsr(`CSR_STIMECMP, 1, 32'hFFFF_FFFF, 1);
    finishTest("reset state");

    // Write masks
    startTest();
    scratchVal = $random(seed);
    writeCsr(`CSR_SSCRATCH, scratchVal, 1);
    readCsr(`CSR_SSCRATCH, 1, scratchVal, 1);
    randVal = $random(seed);
    writeCsr(`CSR_STVEC, randVal, 1);
    readCsr(`CSR_STVEC, 1, randVal & ~32'h2, 1);
    checkVal("stvecOut", stvecOut, randVal & ~32'h2);
    // mtvec written with its reserved mode bit clear
    randVal = $random(seed) & ~32'h2;
    writeCsr(`CSR_MTVEC, randVal, 1);
    readCsr(`CSR_MTVEC, 1, randVal, 1);
    checkVal("mtvecOut", mtvecOut, randVal);
    // MIE, MPIE and MPP must survive an sstatus write
    writeCsr(`CSR_MSTATUS, 32'h0000_1888, 1);
    randVal = $random(seed);
    writeCsr(`CSR_SSTATUS, randVal, 1);
    readCsr(`CSR_MSTATUS, 1, 32'h0000_1888 | (randVal & `SSTATUS_MASK), 1);
    finishTest("write masking");

    // Privilege and address faults
    startTest();
    writeCsr(`CSR_MSCRATCH, 32'hA5A5_0F0F, 1);
    setPriv(PRIV_S);
    writeCsr(`CSR_MSCRATCH, 32'h1234_5678, 0);
    setPriv(PRIV_U);
    writeCsr(`CSR_SSCRATCH, 32'h1234_5678, 0);
    readCsr(`CSR_SSCRATCH, 0, 0, 0);
    setPriv(PRIV_M);
    readCsr(`CSR_MSCRATCH, 1, 32'hA5A5_0F0F, 1);
    readCsr(`CSR_SSCRATCH, 1, scratchVal, 1);
    writeCsr(`CSR_TIME, 32'hFFFF_0000, 0);
    readCsr(`CSR_TIME, 1, 0, 0);
    checkTrue(rdData < 32'hFFFF_0000, "time took the value of a bus write");
    writeCsr(`CSR_TIMEH, 32'h8000_0000, 0);
    readCsr(`CSR_TIMEH, 1, 0, 1);
    writeCsr(12'h3FF, 32'hFFFF_FFFF, 0);
    readCsr(12'h3FF, 0, 0, 0);
    finishTest("privilege errors");

    // TVM gate on satp
    startTest();
    writeCsr(`CSR_MSTATUS, 32'h0010_0000, 1);
    setPriv(PRIV_S);
    writeCsr(`CSR_SATP, 32'h8000_1234, 0);
    setPriv(PRIV_M);
    writeCsr(`CSR_SATP, 32'h8000_1234, 1);
    readCsr(`CSR_SATP, 1, 32'h8000_1234, 1);
    checkVal("satpOut", satpOut, 32'h8000_1234);
    // stimecmp needs TM and STCE both
    setPriv(PRIV_S);
    writeCsr(`CSR_STIMECMP, 32'h0000_0100, 0);
    setPriv(PRIV_M);
    writeCsr(`CSR_MCOUNTEREN, 32'h2, 1);
    setPriv(PRIV_S);
    writeCsr(`CSR_STIMECMP, 32'h0000_0100, 0);
    setPriv(PRIV_M);
    writeCsr(`CSR_MENVCFGH, 32'h8000_0000, 1);
    setPriv(PRIV_S);
    writeCsr(`CSR_STIMECMP, 32'h0000_0100, 1);
    readCsr(`CSR_STIMECMP, 1, 32'h0000_0100, 1);
    setPriv(PRIV_M);
    finishTest("gated registers");

    // Delegated exception followed by a machine one
    startTest();
    writeCsr(`CSR_MSTATUS, 32'h0, 1);
    writeCsr(`CSR_MEDELEG, 32'h4, 1);
    writeCsr(`CSR_MEPC, 32'h0000_4000, 1);
    randVal = $random(seed);
    setPriv(PRIV_S);
    raiseTrap(5'd2, randVal, 32'hDEAD_BEEF);
    setPriv(PRIV_M);
    readCsr(`CSR_SEPC, 1, randVal, 1);
    readCsr(`CSR_SCAUSE, 1, 32'd2, 1);
    readCsr(`CSR_STVAL, 1, 32'hDEAD_BEEF, 1);
    // Only SPP set as the trap came from S mode with SIE clear
    readCsr(`CSR_SSTATUS, 1, 32'h0000_0100, 1);
    readCsr(`CSR_MEPC, 1, 32'h0000_4000, 1);
    checkVal("sepcOut", sepcOut, randVal);
    setPriv(PRIV_S);
    raiseTrap(5'd3, 32'h8000_0080, 32'h0);
    setPriv(PRIV_M);
    readCsr(`CSR_MEPC, 1, 32'h8000_0080, 1);
    readCsr(`CSR_MCAUSE, 1, 32'd3, 1);
    finishTest("trap delegation");

    // Supervisor timer
    startTest();
    writeCsr(`CSR_STIMECMPH, 32'h1, 1);
    writeCsr(`CSR_STIMECMP, 32'h0, 1);
    expectQuiet(1'b0);
    readCsr(`CSR_TIME, 1, 0, 0);
    cmpVal = rdData + 32'd40;
    writeCsr(`CSR_STIMECMP, cmpVal, 1);
    writeCsr(`CSR_STIMECMPH, 32'h0, 1);
    waitIrq(1'b0);
    readCsr(`CSR_TIME, 1, 0, 0);
    checkTrue(rdData >= cmpVal, "time read below stimecmp after sTimerInt rose");
    // Machine timer with its high word still all ones
    writeCsr(`CSR_MTIMECMP, 32'h0, 1);
    expectQuiet(1'b1);
    readCsr(`CSR_TIME, 1, 0, 0);
    cmpVal = rdData + 32'd40;
    writeCsr(`CSR_MTIMECMP, cmpVal, 1);
    writeCsr(`CSR_MTIMECMPH, 32'h0, 1);
    waitIrq(1'b1);
    readCsr(`CSR_TIME, 1, 0, 0);
    checkTrue(rdData >= cmpVal, "time read below mtimecmp after mTimerInt rose");
    finishTest("timer");

    endRun();
  end

endmodule

`default_nettype wire

// ==== csrUnit.f ====
+incdir+hdl
+incdir+verif
hdl/csrPkg.sv
hdl/csrAccessCtl.sv
hdl/machineCsrs.sv
hdl/supervisorCsrs.sv
hdl/csrUnit.sv
verif/csrUnitTb.sv

// ==== Makefile ====
SIM    := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := csrUnitTb
FLIST  := csrUnit.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o $(TOP)

run: compile
	-./$(OBJDIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "All tests passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
